// File: Bender.yml
package:
  name: rvPipe

sources:
  - src/rvPipePkg.sv
  - src/fetchStage.sv
  - src/regFile.sv
  - src/decodeStage.sv
  - src/hazardUnit.sv
  - src/executeStage.sv
  - src/memWbStage.sv
  - src/rvPipeCore.sv
  - target: simulation
    files:
      - sim/tbRvPipe.sv

// File: sim/tbRvPipe.sv
`timescale 1ns/1ps

module tbRvPipe;
	import rvPipePkg::*;

	localparam int numTests     = 6;
	localparam int maxLen       = 40;     // Instructions per program
	localparam int maxStores    = 16;
	localparam int storeTimeout = 200;    // Cycles allowed per store

	logic   iCLK;
	logic   iRST;
	word_t  iAddr;
	instr_t iData;
	logic   dRead;
	logic   dWrite;
	word_t  dAddr;
	word_t  dWdata;
	word_t  dRdata;

	instr_t rom  [64];                    // Instruction ROM, word indexed
	word_t  dmem [256];                   // Data RAM, word indexed

	// Program table and expected stores per entry
	instr_t prog     [numTests][maxLen];
	int     progLen  [numTests];
	string  testName [numTests];
	word_t  expAddr  [numTests][maxStores];
	word_t  expData  [numTests][maxStores];
	int     expCount [numTests];

	int seed;
	int curTest;                          // Entry being assembled

	rvPipeCore dut (.iCLK, .iRST, .iAddr, .iData, .dRead, .dWrite, .dAddr, .dWdata, .dRdata);

	always #2 iCLK = ~iCLK;

	// Both buses answer on the falling edge, ready for the next rising edge
	always @(negedge iCLK)
	begin
		iData  = rom[iAddr[7:2]];
		dRdata = dmem[dAddr[9:2]];
	end

	always @(posedge iCLK)
	begin
		if (dWrite)
			dmem[dAddr[9:2]] <= dWdata;       // Word store
	end

	// *****************************************************************
	// Encoders
	function automatic instr_t encR(logic [6:0] f7, logic [2:0] f3, regAddr_t rd,
		regAddr_t rs1, regAddr_t rs2);
		return {f7, rs2, rs1, f3, rd, opR};
	endfunction

	function automatic instr_t encI(logic [2:0] f3, regAddr_t rd, regAddr_t rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, opI};
	endfunction

	function automatic instr_t encLw(regAddr_t rd, regAddr_t rs1, logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, opLoad};
	endfunction

	function automatic instr_t encSw(regAddr_t rs2, regAddr_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	// Byte offset, bit 0 dropped
	function automatic instr_t encB(logic [2:0] f3, regAddr_t rs1, regAddr_t rs2,
		logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic instr_t encJal(regAddr_t rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	function automatic word_t fillWord(int i);
		return {16'hDA7A, 8'h00, i[7:0]};  // Unique per RAM word
	endfunction

	// ISA arithmetic, alt selects sub
	function automatic word_t aluRef(logic [2:0] f3, logic alt, word_t x, word_t y);
		case (f3)
			3'b000:  return alt ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b100:  return x ^ y;
			3'b101:  return x >> y[4:0];     // Logical
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	task automatic emit(input instr_t ins);
		prog[curTest][progLen[curTest]] = ins;
		progLen[curTest]++;
	endtask

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped");
	endtask

	// *****************************************************************
	// Compare tasks
	task automatic checkWord(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkAddr(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected address %h, actual %h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			abortRun();
		end
	endtask

	task automatic waitStore(input string name);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge iCLK);
			cycles++;
		end
		while (!dWrite && cycles < storeTimeout);
		if (!dWrite)
		begin
			$display("Timeout in test %s: no store seen within %0d cycles", name, storeTimeout);
			abortRun();
		end
	endtask

	// *****************************************************************
	// Program table
	task automatic buildPrograms();
		integer      rnd;
		logic [11:0] a;
		logic [11:0] b;
		logic [2:0]  rF3 [8];
		logic [2:0]  iF3 [5];
		int          off;
		rF3 = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
		iF3 = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
		for (int t = 0; t < numTests; t++)
		begin
			progLen[t] = 0;
			for (int k = 0; k < maxLen; k++)
				prog[t][k] = nopInstr;
		end

		// Dependent chain, operands from EX/MEM/WB
		curTest = 0;
		testName[0] = "forwarding";
		rnd = $random(seed);
		a = rnd[11:0];
		rnd = $random(seed);
		b = rnd[11:0];
		emit(encI(3'b000, 5'd1, 5'd0, a));
		emit(encI(3'b000, 5'd2, 5'd1, b));
		emit(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
		emit(encR(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
		emit(encSw(5'd4, 5'd0, 12'd12));      // Store data from MEM
		emit(encSw(5'd3, 5'd0, 12'd8));
		emit(encSw(5'd2, 5'd0, 12'd4));
		emit(encSw(5'd1, 5'd0, 12'd0));
		emit(encJal(5'd0, 21'd0));            // Park

		// Every R and I op on random operands
		curTest = 1;
		testName[1] = "alu ops";
		rnd = $random(seed);
		a = rnd[11:0];
		rnd = $random(seed);
		b = rnd[11:0];
		emit(encI(3'b000, 5'd1, 5'd0, a));
		emit(encI(3'b000, 5'd2, 5'd0, b));
		for (int k = 0; k < 8; k++)
		begin
			off = 4 * k;
			emit(encR(k == 1 ? 7'h20 : 7'h00, rF3[k], 5'd10, 5'd1, 5'd2));
			emit(encSw(5'd10, 5'd0, off[11:0]));
		end
		for (int k = 0; k < 5; k++)
		begin
			off = 32 + 4 * k;
			rnd = $random(seed);
			emit(encI(iF3[k], 5'd10, 5'd1, rnd[11:0]));
			emit(encSw(5'd10, 5'd0, off[11:0]));
		end
		emit(encJal(5'd0, 21'd0));

		// Loads used right away
		curTest = 2;
		testName[2] = "load use";
		rnd = $random(seed);
		a = rnd[11:0];
		emit(encI(3'b000, 5'd1, 5'd0, a));
		emit(encSw(5'd1, 5'd0, 12'd64));
		emit(encLw(5'd2, 5'd0, 12'd64));
		emit(encR(7'h00, 3'b000, 5'd3, 5'd2, 5'd2));
		emit(encSw(5'd3, 5'd0, 12'd68));
		emit(encLw(5'd4, 5'd0, 12'd68));
		emit(encSw(5'd4, 5'd0, 12'd72));      // Store data straight from a load
		emit(encJal(5'd0, 21'd0));

		// Taken and untaken beq/bne, some on fresh loads
		curTest = 3;
		testName[3] = "branches";
		rnd = $random(seed);
		a = {3'b000, rnd[8:0]} | 12'd64;     // Never 23
		emit(encI(3'b000, 5'd3, 5'd0, 12'd7));
		emit(encI(3'b000, 5'd1, 5'd0, a));
		emit(encI(3'b000, 5'd2, 5'd0, a));
		emit(encB(3'b000, 5'd1, 5'd2, 13'd8));   // Taken, operands from MEM and EX
		emit(encI(3'b000, 5'd3, 5'd0, 12'd1));
		emit(encB(3'b001, 5'd1, 5'd2, 13'd8));   // Not taken
		emit(encI(3'b000, 5'd3, 5'd3, 12'd16));
		emit(encSw(5'd3, 5'd0, 12'h080));
		emit(encSw(5'd1, 5'd0, 12'h084));
		emit(encLw(5'd4, 5'd0, 12'h084));
		emit(encB(3'b001, 5'd4, 5'd2, 13'd8));   // Load in EX, not taken
		emit(encI(3'b000, 5'd3, 5'd3, 12'd32));
		emit(encLw(5'd5, 5'd0, 12'h080));
		emit(encI(3'b000, 5'd6, 5'd0, 12'd1));
		emit(encB(3'b001, 5'd5, 5'd3, 13'd8));   // Load in MEM, taken
		emit(encI(3'b000, 5'd3, 5'd0, 12'd0));
		emit(encB(3'b000, 5'd4, 5'd5, 13'd8));
		emit(encI(3'b000, 5'd3, 5'd3, 12'd64));
		emit(encSw(5'd3, 5'd0, 12'h088));
		emit(encJal(5'd0, 21'd0));

		// Link value and landing point
		curTest = 4;
		testName[4] = "jal";
		emit(encI(3'b000, 5'd1, 5'd0, 12'd5));
		emit(encJal(5'd5, 21'd12));
		emit(encI(3'b000, 5'd1, 5'd0, 12'd99));
		emit(encI(3'b000, 5'd1, 5'd0, 12'd77));
		emit(encSw(5'd5, 5'd0, 12'h040));
		emit(encSw(5'd1, 5'd0, 12'h044));
		emit(encJal(5'd7, 21'd8));
		emit(encI(3'b000, 5'd1, 5'd0, 12'd1));
		emit(encR(7'h00, 3'b000, 5'd8, 5'd7, 5'd1));   // Link used at once
		emit(encSw(5'd8, 5'd0, 12'h048));
		emit(encJal(5'd0, 21'd0));

		curTest = 5;
		testName[5] = "x0";
		emit(encI(3'b000, 5'd0, 5'd0, 12'd123));
		emit(encSw(5'd0, 5'd0, 12'h020));
		emit(encI(3'b000, 5'd1, 5'd0, 12'd9));
		emit(encR(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
		emit(encR(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
		emit(encSw(5'd2, 5'd0, 12'h024));
		emit(encJal(5'd0, 21'd0));
	endtask

	// *****************************************************************
	// In-order instruction model, fills the expected-store table
	task automatic runReference(input int t);
		word_t  regs [32];
		word_t  mem [256];
		word_t  pc, nextPc, a, b, ea, res;
		word_t  immI, immS, immB, immJ;
		instr_t ins;
		logic   wr;
		logic   done;
		int     steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = fillWord(i);
		pc = resetPc;
		expCount[t] = 0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200)
		begin
			ins  = (pc[7:2] < progLen[t]) ? prog[t][pc[7:2]] : nopInstr;
			a    = regs[ins[19:15]];
			b    = regs[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			nextPc = pc + 32'd4;
			wr  = 1'b0;
			res = '0;
			case (ins[6:0])
				opR:
				begin
					res = aluRef(ins[14:12], ins[30], a, b);
					wr  = 1'b1;
				end
				opI:
				begin
					res = aluRef(ins[14:12], 1'b0, a, immI);
					wr  = 1'b1;
				end
				opLoad:
				begin
					ea  = a + immI;
					res = mem[ea[9:2]];
					wr  = 1'b1;
				end
				opStore:
				begin
					ea = a + immS;
					mem[ea[9:2]] = b;
					expAddr[t][expCount[t]] = ea;
					expData[t][expCount[t]] = b;
					expCount[t]++;
				end
				opBranch:
				begin
					if ((ins[14:12] == 3'b000) ? (a == b) : (a != b))
						nextPc = pc + immB;
				end
				opJal:
				begin
					res    = pc + 32'd4;
					wr     = 1'b1;
					nextPc = pc + immJ;
					done   = (immJ == '0);          // Self loop ends the program
				end
				default: ;
			endcase
			if (wr && ins[11:7] != 5'd0)
				regs[ins[11:7]] = res;
			pc = nextPc;
			steps++;
		end
	endtask

	// Reset, load, then one check pair per store
	task automatic applyTest(input int t);
		@(negedge iCLK);
		iRST = 1'b1;
		for (int i = 0; i < 64; i++)
			rom[i] = (i < progLen[t]) ? prog[t][i] : nopInstr;
		for (int i = 0; i < 256; i++)
			dmem[i] = fillWord(i);
		repeat (5) @(negedge iCLK);
		iRST = 1'b0;
		checkAddr({testName[t], " reset pc"}, resetPc, iAddr);
		checkBit({testName[t], " reset dRead"}, 1'b0, dRead);
		checkBit({testName[t], " reset dWrite"}, 1'b0, dWrite);
		for (int k = 0; k < expCount[t]; k++)
		begin
			waitStore(testName[t]);
			checkBit($sformatf("%s store %0d read", testName[t], k), 1'b0, dRead);
			checkAddr($sformatf("%s store %0d", testName[t], k), expAddr[t][k], dAddr);
			checkWord($sformatf("%s store %0d data", testName[t], k), expData[t][k], dWdata);
		end
	endtask

	initial
	begin
		iCLK       = 1'b0;
		iRST       = 1'b1;
		iData      = nopInstr;
		dRdata     = '0;
		seed       = 41194;
		buildPrograms();
		for (int t = 0; t < numTests; t++)
			runReference(t);
		for (int t = 0; t < numTests; t++)
			applyTest(t);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                stall,
	input  rvPipePkg::word_t    idPc,
	input  rvPipePkg::word_t    idPc4,
	input  rvPipePkg::instr_t   idInstr,
	input  rvPipePkg::word_t    rdata1,
	input  rvPipePkg::word_t    rdata2,
	input  rvPipePkg::fwdSel_t  fwdRs1,
	input  rvPipePkg::fwdSel_t  fwdRs2,
	input  rvPipePkg::word_t    exResult,
	input  rvPipePkg::word_t    memResult,
	input  rvPipePkg::word_t    wbResult,
	output rvPipePkg::regAddr_t rs1,
	output rvPipePkg::regAddr_t rs2,
	output logic                idIsBranch,     // To hazard unit
	output logic                taken,          // Branch taken or jal
	output rvPipePkg::pcSel_t   pcSel,
	output rvPipePkg::word_t    branchTarget,
	output rvPipePkg::word_t    jalTarget,
	output rvPipePkg::word_t    exPc4,
	output rvPipePkg::word_t    exRs1Val,
	output rvPipePkg::word_t    exRs2Val,
	output rvPipePkg::word_t    exImm,
	output rvPipePkg::regAddr_t exRs1,
	output rvPipePkg::regAddr_t exRs2,
	output rvPipePkg::regAddr_t exRd,
	output rvPipePkg::aluOp_t   exAluOp,
	output logic                exUseImm,
	output logic                exMemRead,
	output logic                exMemWrite,
	output logic                exRegWrite,
	output rvPipePkg::wbSel_t   exWbSel
);
	import rvPipePkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	regAddr_t   rd;
	word_t      immI;
	word_t      immS;
	word_t      immB;
	word_t      immJ;
	word_t      imm;
	aluOp_t     aluOp;
	wbSel_t     wbSel;
	logic       useImm;
	logic       memRead;
	logic       memWrite;
	logic       regWrite;
	logic       isJal;
	word_t      cmpA;
	word_t      cmpB;
	logic       branchTaken;

	// ********************************************************************
	// Fields and immediates
	assign opcode = idInstr[6:0];
	assign funct3 = idInstr[14:12];
	assign rd     = idInstr[11:7];
	assign rs1    = idInstr[19:15];
	assign rs2    = idInstr[24:20];

	assign immI = {{20{idInstr[31]}}, idInstr[31:20]};
	assign immS = {{20{idInstr[31]}}, idInstr[31:25], idInstr[11:7]};
	assign immB = {{19{idInstr[31]}}, idInstr[31], idInstr[7], idInstr[30:25],
		idInstr[11:8], 1'b0};
	assign immJ = {{11{idInstr[31]}}, idInstr[31], idInstr[19:12], idInstr[20],
		idInstr[30:21], 1'b0};

	assign branchTarget = idPc + immB;        // Target adders
	assign jalTarget    = idPc + immJ;

	// funct3 to ALU op, sub only for R-type
	function automatic aluOp_t aluFromFunct(logic [2:0] f3, logic isSub);
		case (f3)
			3'b000:  return isSub ? aluSub : aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b100:  return aluXor;
			3'b101:  return aluSrl;
			3'b110:  return aluOr;
			3'b111:  return aluAnd;
			default: return aluAdd;           // sltu not supported
		endcase
	endfunction

	// Branch operand from the youngest producer
	function automatic word_t fwdValue(fwdSel_t sel, word_t regVal);
		case (sel)
			fwdFromEx:  return exResult;
			fwdFromMem: return memResult;
			fwdFromWb:  return wbResult;
			default:    return regVal;
		endcase
	endfunction

	// ********************************************************************
	// Control decoder
	always_comb
	begin
		aluOp      = aluAdd;
		wbSel      = wbFromAlu;
		imm        = immI;
		useImm     = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		regWrite   = 1'b0;
		isJal      = 1'b0;
		idIsBranch = 1'b0;
		case (opcode)
			opR:
			begin
				regWrite = 1'b1;
				aluOp    = aluFromFunct(funct3, idInstr[30]);
			end
			opI:
			begin
				regWrite = 1'b1;
				useImm   = 1'b1;
				aluOp    = aluFromFunct(funct3, 1'b0);
			end
			opLoad:
			begin
				regWrite = 1'b1;
				useImm   = 1'b1;
				memRead  = 1'b1;
				wbSel    = wbFromLoad;
			end
			opStore:
			begin
				useImm   = 1'b1;
				memWrite = 1'b1;
				imm      = immS;
			end
			opBranch: idIsBranch = 1'b1;
			opJal:
			begin
				regWrite = 1'b1;
				isJal    = 1'b1;
				wbSel    = wbFromPc4;         // rd gets return address
			end
			default: ;                        // Unsupported ops act as nop
		endcase
	end

	// beq / bne compare on forwarded values
	always_comb
	begin
		cmpA        = fwdValue(fwdRs1, rdata1);
		cmpB        = fwdValue(fwdRs2, rdata2);
		branchTaken = idIsBranch && ((cmpA == cmpB) != funct3[0]);
		if (isJal)
			pcSel = pcJal;
		else if (branchTaken)
			pcSel = pcBranch;
		else
			pcSel = pcSeq;
	end

	assign taken = (pcSel != pcSeq);

	// ********************************************************************
	// ID/EX register
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
		end
		else
		begin
			exMemRead  <= memRead && !stall;  // Bubble on stall
			exMemWrite <= memWrite && !stall;
			exRegWrite <= regWrite && !stall;
		end
	end

	always_ff @(posedge iCLK)
	begin
		exPc4    <= idPc4;
		exRs1Val <= rdata1;                   // Refreshed by EX forwarding
		exRs2Val <= rdata2;
		exImm    <= imm;
		exRs1    <= rs1;
		exRs2    <= rs2;
		exRd     <= rd;
		exAluOp  <= aluOp;
		exUseImm <= useImm;
		exWbSel  <= wbSel;
	end

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic                iCLK,
	input  logic                iRST,
	input  rvPipePkg::word_t    exPc4,
	input  rvPipePkg::word_t    exRs1Val,
	input  rvPipePkg::word_t    exRs2Val,
	input  rvPipePkg::word_t    exImm,
	input  rvPipePkg::regAddr_t exRd,
	input  rvPipePkg::aluOp_t   exAluOp,
	input  logic                exUseImm,
	input  logic                exMemRead,
	input  logic                exMemWrite,
	input  logic                exRegWrite,
	input  rvPipePkg::wbSel_t   exWbSel,
	input  rvPipePkg::fwdSel_t  fwdA,
	input  rvPipePkg::fwdSel_t  fwdB,
	input  rvPipePkg::word_t    memResult,
	input  rvPipePkg::word_t    wbResult,
	output rvPipePkg::word_t    exResult,       // Forwarded to decode
	output rvPipePkg::word_t    memAluResult,
	output rvPipePkg::word_t    memStoreData,
	output rvPipePkg::regAddr_t memRd,
	output logic                memMemRead,
	output logic                memMemWrite,
	output logic                memRegWrite,
	output rvPipePkg::wbSel_t   memWbSel,
	output rvPipePkg::word_t    memPc4
);
	import rvPipePkg::*;

	word_t opA;
	word_t rs2Fwd;
	word_t opB;
	word_t aluOut;

	function automatic word_t fwdValue(fwdSel_t sel, word_t regVal);
		case (sel)
			fwdFromMem: return memResult;
			fwdFromWb:  return wbResult;
			default:    return regVal;
		endcase
	endfunction

	// Operand muxes
	always_comb
	begin
		opA    = fwdValue(fwdA, exRs1Val);
		rs2Fwd = fwdValue(fwdB, exRs2Val);   // Also the store data
		opB    = exUseImm ? exImm : rs2Fwd;
	end

	// ********************************************************************
	// ALU
	always_comb
	begin
		case (exAluOp)
			aluAdd:  aluOut = opA + opB;
			aluSub:  aluOut = opA - opB;
			aluAnd:  aluOut = opA & opB;
			aluOr:   aluOut = opA | opB;
			aluXor:  aluOut = opA ^ opB;
			aluSlt:  aluOut = word_t'($signed(opA) < $signed(opB));
			aluSll:  aluOut = opA << opB[4:0];
			aluSrl:  aluOut = opA >> opB[4:0];
			default: aluOut = '0;
		endcase
	end

	// jal writes PC+4 so forwarding sees the real rd value
	assign exResult = (exWbSel == wbFromPc4) ? exPc4 : aluOut;

	// EX/MEM register
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			memMemRead  <= 1'b0;
			memMemWrite <= 1'b0;
			memRegWrite <= 1'b0;
		end
		else
		begin
			memMemRead  <= exMemRead;
			memMemWrite <= exMemWrite;
			memRegWrite <= exRegWrite;
		end
	end

	always_ff @(posedge iCLK)
	begin
		memAluResult <= exResult;
		memStoreData <= rs2Fwd;
		memRd        <= exRd;
		memWbSel     <= exWbSel;
		memPc4       <= exPc4;
	end

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
	input  logic              iCLK,
	input  logic              iRST,
	input  logic              stall,          // Hold PC and IF/ID
	input  logic              flush,          // Squash the fetched instruction
	input  rvPipePkg::pcSel_t pcSel,
	input  rvPipePkg::word_t  branchTarget,
	input  rvPipePkg::word_t  jalTarget,
	input  rvPipePkg::instr_t iData,
	output rvPipePkg::word_t  iAddr,
	output rvPipePkg::word_t  idPc,
	output rvPipePkg::word_t  idPc4,
	output rvPipePkg::instr_t idInstr
);
	import rvPipePkg::*;

	word_t pc;
	word_t pc4;
	word_t nextPc;

	assign pc4   = pc + 32'd4;
	assign iAddr = pc;                        // Zero-wait fetch

	// Next PC, decode resolves redirects
	always_comb
	begin
		case (pcSel)
			pcBranch: nextPc = branchTarget;
			pcJal:    nextPc = jalTarget;
			default:  nextPc = pc4;
		endcase
	end

	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			pc      <= resetPc;
			idInstr <= nopInstr;              // IF/ID starts as a bubble
		end
		else
		begin
			if (!stall)
				pc <= nextPc;
			if (flush)
				idInstr <= nopInstr;          // Instruction behind a taken jump
			else if (!stall)
				idInstr <= iData;
		end
	end

	// PC copies travel with the instruction
	always_ff @(posedge iCLK)
	begin
		if (!stall)
		begin
			idPc  <= pc;
			idPc4 <= pc4;
		end
	end

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic                idIsBranch,
	input  logic                taken,
	input  rvPipePkg::regAddr_t idRs1,
	input  rvPipePkg::regAddr_t idRs2,
	input  rvPipePkg::regAddr_t exRs1,
	input  rvPipePkg::regAddr_t exRs2,
	input  rvPipePkg::regAddr_t exRd,
	input  rvPipePkg::regAddr_t memRd,
	input  rvPipePkg::regAddr_t wbRd,
	input  logic                exRegWrite,
	input  logic                exMemRead,
	input  logic                memRegWrite,
	input  logic                memMemRead,
	input  logic                wbRegWrite,
	output logic                stall,
	output logic                flush,
	output rvPipePkg::fwdSel_t  fwdRs1,         // Decode operands
	output rvPipePkg::fwdSel_t  fwdRs2,
	output rvPipePkg::fwdSel_t  fwdA,           // Execute operands
	output rvPipePkg::fwdSel_t  fwdB
);
	import rvPipePkg::*;

	logic loadUseEx;
	logic loadUseMem;

	// Youngest producer of r, loads only forward from WB
	function automatic fwdSel_t pickSrc(regAddr_t r, logic fromEx);
		if (r == '0)
			return fwdFromReg;                // x0 never forwarded
		if (fromEx && exRegWrite && !exMemRead && exRd == r)
			return fwdFromEx;
		if (memRegWrite && !memMemRead && memRd == r)
			return fwdFromMem;
		if (wbRegWrite && wbRd == r)
			return fwdFromWb;
		return fwdFromReg;
	endfunction

	always_comb
	begin
		fwdRs1 = pickSrc(idRs1, 1'b1);
		fwdRs2 = pickSrc(idRs2, 1'b1);
		fwdA   = pickSrc(exRs1, 1'b0);       // Own stage never feeds itself
		fwdB   = pickSrc(exRs2, 1'b0);
	end

	// ********************************************************************
	// Load-use detection
	assign loadUseEx  = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);
	assign loadUseMem = memMemRead && memRd != '0 && (memRd == idRs1 || memRd == idRs2);

	// Branches compare in ID so they also wait on a load in MEM
	assign stall = loadUseEx || (idIsBranch && loadUseMem);
	assign flush = taken && !stall;

endmodule

// File: src/memWbStage.sv
`timescale 1ns/1ps

module memWbStage (
	input  logic                iCLK,
	input  logic                iRST,
	input  rvPipePkg::word_t    memAluResult,
	input  rvPipePkg::word_t    memStoreData,
	input  rvPipePkg::regAddr_t memRd,
	input  logic                memMemRead,
	input  logic                memMemWrite,
	input  logic                memRegWrite,
	input  rvPipePkg::wbSel_t   memWbSel,
	input  rvPipePkg::word_t    memPc4,
	input  rvPipePkg::word_t    dRdata,         // Same-cycle read data
	output logic                dRead,
	output logic                dWrite,
	output rvPipePkg::word_t    dAddr,
	output rvPipePkg::word_t    dWdata,
	output rvPipePkg::regAddr_t wbRd,
	output logic                wbRegWrite,
	output rvPipePkg::word_t    wbResult
);
	import rvPipePkg::*;

	word_t  wbAluData;
	word_t  wbLoadData;
	word_t  wbPc4;
	wbSel_t wbSel;

	// Data bus, word accesses only
	assign dRead  = memMemRead;
	assign dWrite = memMemWrite;
	assign dAddr  = memAluResult;
	assign dWdata = memStoreData;

	// MEM/WB register
	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
			wbRegWrite <= 1'b0;
		else
			wbRegWrite <= memRegWrite;
	end

	always_ff @(posedge iCLK)
	begin
		wbRd       <= memRd;
		wbAluData  <= memAluResult;
		wbLoadData <= dRdata;
		wbPc4      <= memPc4;
		wbSel      <= memWbSel;
	end

	// Writeback source
	always_comb
	begin
		case (wbSel)
			wbFromPc4:  wbResult = wbPc4;
			wbFromLoad: wbResult = wbLoadData;
			default:    wbResult = wbAluData;
		endcase
	end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                iCLK,
	input  logic                iRST,
	input  rvPipePkg::regAddr_t rs1,
	input  rvPipePkg::regAddr_t rs2,
	input  rvPipePkg::regAddr_t rd,
	input  rvPipePkg::word_t    wdata,
	input  logic                we,
	output rvPipePkg::word_t    rdata1,
	output rvPipePkg::word_t    rdata2
);
	import rvPipePkg::*;

	word_t regs [1:31];                       // x0 has no storage

	// Read port with write-before-read bypass
	function automatic word_t readReg(regAddr_t addr);
		if (addr == '0)
			return '0;
		else if (we && addr == rd)
			return wdata;                     // Same-cycle write wins
		else
			return regs[addr];
	endfunction

	always_ff @(posedge iCLK or posedge iRST)
	begin
		if (iRST)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && rd != '0)
			regs[rd] <= wdata;                // Writes to x0 dropped
	end

	always_comb
	begin
		rdata1 = readReg(rs1);
		rdata2 = readReg(rs2);
	end

endmodule

// File: src/rvPipeCore.sv
`timescale 1ns/1ps

module rvPipeCore (
	input  logic              iCLK,
	input  logic              iRST,
	output rvPipePkg::word_t  iAddr,            // Instruction bus
	input  rvPipePkg::instr_t iData,
	output logic              dRead,            // Data bus
	output logic              dWrite,
	output rvPipePkg::word_t  dAddr,
	output rvPipePkg::word_t  dWdata,
	input  rvPipePkg::word_t  dRdata
);
	import rvPipePkg::*;

	// ********************************************************************
	// Stage to stage wires
	logic     stall, flush, taken, idIsBranch;
	pcSel_t   pcSel;
	word_t    branchTarget, jalTarget, idPc, idPc4, rdata1, rdata2;
	instr_t   idInstr;
	regAddr_t idRs1, idRs2, exRs1, exRs2, exRd, memRd, wbRd;
	fwdSel_t  fwdRs1, fwdRs2, fwdA, fwdB;
	word_t    exPc4, exRs1Val, exRs2Val, exImm, exResult;
	aluOp_t   exAluOp;
	logic     exUseImm, exMemRead, exMemWrite, exRegWrite;
	wbSel_t   exWbSel, memWbSel;
	word_t    memAluResult, memStoreData, memPc4, wbResult;
	logic     memMemRead, memMemWrite, memRegWrite, wbRegWrite;

	fetchStage uFetch (.iCLK, .iRST, .stall, .flush, .pcSel, .branchTarget, .jalTarget,
		.iData, .iAddr, .idPc, .idPc4, .idInstr);

	regFile uRegs (.iCLK, .iRST, .rs1(idRs1), .rs2(idRs2), .rd(wbRd), .wdata(wbResult),
		.we(wbRegWrite), .rdata1, .rdata2);

	decodeStage uDecode (.iCLK, .iRST, .stall, .idPc, .idPc4, .idInstr, .rdata1, .rdata2,
		.fwdRs1, .fwdRs2, .exResult, .memResult(memAluResult), .wbResult,
		.rs1(idRs1), .rs2(idRs2), .idIsBranch, .taken, .pcSel, .branchTarget, .jalTarget,
		.exPc4, .exRs1Val, .exRs2Val, .exImm, .exRs1, .exRs2, .exRd, .exAluOp, .exUseImm,
		.exMemRead, .exMemWrite, .exRegWrite, .exWbSel);

	hazardUnit uHazard (.idIsBranch, .taken, .idRs1, .idRs2, .exRs1, .exRs2, .exRd,
		.memRd, .wbRd, .exRegWrite, .exMemRead, .memRegWrite, .memMemRead, .wbRegWrite,
		.stall, .flush, .fwdRs1, .fwdRs2, .fwdA, .fwdB);

	executeStage uExecute (.iCLK, .iRST, .exPc4, .exRs1Val, .exRs2Val, .exImm, .exRd,
		.exAluOp, .exUseImm, .exMemRead, .exMemWrite, .exRegWrite, .exWbSel, .fwdA, .fwdB,
		.memResult(memAluResult), .wbResult, .exResult, .memAluResult, .memStoreData,
		.memRd, .memMemRead, .memMemWrite, .memRegWrite, .memWbSel, .memPc4);

	// Drives the data bus and the register file write port
	memWbStage uMemWb (.iCLK, .iRST, .memAluResult, .memStoreData, .memRd, .memMemRead,
		.memMemWrite, .memRegWrite, .memWbSel, .memPc4, .dRdata, .dRead, .dWrite, .dAddr,
		.dWdata, .wbRd, .wbRegWrite, .wbResult);

endmodule

// File: src/rvPipePkg.sv
package rvPipePkg;

	// *******************************************************************
	// Widths
	localparam int xlen = 32;                 // One word

	typedef logic [xlen-1:0] word_t;          // Data or address
	typedef logic [4:0]      regAddr_t;       // Register index
	typedef logic [31:0]     instr_t;         // Raw instruction word

	// *******************************************************************
	// Control encodings
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr,
		aluXor, aluSlt, aluSll, aluSrl
	} aluOp_t;

	// Operand source, register file value unless a newer producer exists
	typedef enum logic [1:0] {fwdFromReg, fwdFromEx, fwdFromMem, fwdFromWb} fwdSel_t;

	typedef enum logic [1:0] {wbFromAlu, wbFromPc4, wbFromLoad} wbSel_t;

	typedef enum logic [1:0] {pcSeq, pcBranch, pcJal} pcSel_t;

	// Major opcodes
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opI      = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;

	// *******************************************************************
	// Reset and bubble values
	localparam instr_t nopInstr = 32'h0000_0013;   // addi x0,x0,0
	localparam word_t  resetPc  = 32'h0000_0000;

endpackage

// File: tb.f
src/rvPipePkg.sv
src/fetchStage.sv
src/regFile.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memWbStage.sv
src/rvPipeCore.sv
sim/tbRvPipe.sv
